/* design/lspcRegsPkg.sv */
// LSPC CPU register map, mode fields and CPU request bundle
`default_nettype none

package lspcRegsPkg;

	// ============================================================
	// Register word offsets on the 3-bit CPU address
	// ============================================================

	// Address load, also starts a prefetch read
	localparam logic [2:0] REG_VRAMADDR = 3'd0;
	// Write data port, read-back of latched VRAM word
	localparam logic [2:0] REG_VRAMRW = 3'd1;
	// Address step applied after each VRAM write
	localparam logic [2:0] REG_VRAMMOD = 3'd2;
	// Mode register, auto-animation speed lives here
	localparam logic [2:0] REG_LSPCMODE = 3'd3;

	// ============================================================
	// LSPCMODE field positions
	// ============================================================

	// Speed field is 8 bits wide, bits 15:8
	localparam int AA_SPEED_LSB = 8;

	// ============================================================
	// CPU side request
	// ============================================================

	// One bus transfer as seen by the register block
	// wr is a single-cycle strobe
	// rd is held while the CPU samples read data
	typedef struct packed
	{
		// Word offset
		logic [2:0] addr;
		// Write strobe
		logic wr;
		// Read select level
		logic rd;
		// Write payload
		logic [15:0] wdata;
	} cpuReq_t;

endpackage

`default_nettype wire

/* design/vramBusPkg.sv */
// Slow VRAM bus constants and request bundle for the access sequencer
`default_nettype none

package vramBusPkg;

	// ============================================================
	// Memory slot sequence
	// ============================================================

	// Phases in one memory cycle
	localparam int SLOT_COUNT = 8;
	// Phase handed to CPU accesses
	localparam int CPU_SLOT = 7;

	// ============================================================
	// Slow VRAM geometry
	// ============================================================

	// 32K words
	localparam int VRAM_AW = 15;
	localparam int VRAM_DW = 16;

	// Request driven to the external slow VRAM
	// we and re never both high
	typedef struct packed
	{
		logic [VRAM_AW-1:0] addr;
		logic [VRAM_DW-1:0] wdata;
		logic we;
		logic re;
	} vramReq_t;

endpackage

`default_nettype wire

/* design/slotSequencer.sv */
// Slot sequencer, runs the 8-phase memory cycle and flags the CPU slot
`timescale 1ns/1ns
`default_nettype none

module slotSequencer
(
	input wire logic CLK_24M,
	input wire logic T73A_OUT,
	output logic cpuSlot
);
	import vramBusPkg::*;

	// Phase counter width
	localparam int PHASE_W = $clog2(SLOT_COUNT);

	logic [PHASE_W-1:0] phase;

	// Phase wraps after SLOT_COUNT cycles
	// Strobe registered one phase early so it lines up with CPU_SLOT
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			phase <= '0;
			cpuSlot <= 1'b0;
		end
		else
		begin
			if (phase == PHASE_W'(SLOT_COUNT - 1))
				phase <= '0;
			else
				phase <= phase + 1'b1;
			cpuSlot <= (phase == PHASE_W'(CPU_SLOT - 1));
		end
	end

	// Strobe period is exactly one memory cycle
	aSlotPeriod: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		cpuSlot |=> !cpuSlot [*SLOT_COUNT-1] ##1 cpuSlot)
		else $error("cpuSlot period broken");

endmodule

`default_nettype wire

/* design/vramAccessFsm.sv */
// VRAM access FSM, holds one CPU request and issues it after the CPU slot
`timescale 1ns/1ns
`default_nettype none

module vramAccessFsm
(
	input wire logic CLK_24M,
	input wire logic T73A_OUT,
	input wire logic cpuSlot,
	input wire logic wrReq,
	input wire logic rdReq,
	input wire logic [15:0] vramAddr,
	input wire logic [15:0] vramWdata,
	input wire logic [15:0] svramRdata,
	output vramBusPkg::vramReq_t svram,
	output logic writeDone,
	output logic [15:0] rdata
);
	import vramBusPkg::*;

	typedef enum logic [1:0]
	{
		IDLE,
		WRITE_PENDING,
		READ_PENDING,
		ACCESS
	} accState_t;

	accState_t state;
	accState_t stateNext;
	// Kind of the access being issued
	logic opIsWrite;
	logic accWe;
	logic accRe;

	// ============================================================
	// Next state
	// ============================================================

	always_comb
	begin
		stateNext = state;
		case (state)
			IDLE:
			begin
				// Write wins, though both never come together
				if (wrReq)
					stateNext = WRITE_PENDING;
				else if (rdReq)
					stateNext = READ_PENDING;
			end
			WRITE_PENDING, READ_PENDING:
			begin
				// Wait out the sprite/fix slots
				if (cpuSlot)
					stateNext = ACCESS;
			end
			default:
				stateNext = IDLE;
		endcase
	end

	// ============================================================
	// State, done pulse and read latch
	// ============================================================

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			state <= IDLE;
			opIsWrite <= 1'b0;
			writeDone <= 1'b0;
			rdata <= '0;
		end
		else
		begin
			state <= stateNext;
			// Remember the request kind before entering ACCESS
			if (state == WRITE_PENDING || state == READ_PENDING)
				opIsWrite <= (state == WRITE_PENDING);
			// Address stepping hangs off this
			writeDone <= accWe;
			// Combinational VRAM, data valid in the re cycle
			if (accRe)
				rdata <= svramRdata;
		end
	end

	// One-cycle strobes during ACCESS only
	assign accWe = (state == ACCESS) && opIsWrite;
	assign accRe = (state == ACCESS) && !opIsWrite;

	// Address and data straight from the register block
	assign svram = '{addr: vramAddr[VRAM_AW-1:0], wdata: vramWdata, we: accWe, re: accRe};

	// Waiting request goes out within one memory cycle
	aServed: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		(state == WRITE_PENDING || state == READ_PENDING) |->
			##[1:SLOT_COUNT] (state == ACCESS))
		else $error("pending VRAM access not served within a memory cycle");

	// Bus cycle sits right behind the sequencer's CPU slot
	aInSlot: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		(svram.we || svram.re) |-> $past(cpuSlot))
		else $error("svram access outside CPU slot");

	// CPU spacing rule, no second request while one waits
	aNoOverrun: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		(wrReq || rdReq) |-> (state == IDLE))
		else $error("VRAM request while access pending");

endmodule

`default_nettype wire

/* design/cpuVramRegs.sv */
// CPU register block, VRAM address/data/modulo and mode, read-back mux
`timescale 1ns/1ns
`default_nettype none

module cpuVramRegs
(
	input wire logic CLK_24M,
	input wire logic T73A_OUT,
	input wire lspcRegsPkg::cpuReq_t cpu,
	input wire logic writeDone,
	input wire logic [15:0] rdata,
	input wire logic [2:0] aaCount,
	output logic wrReq,
	output logic rdReq,
	output logic [15:0] vramAddr,
	output logic [15:0] vramWdata,
	output logic [7:0] aaSpeed,
	output logic [15:0] cpuRdata
);
	import lspcRegsPkg::*;

	// Address step, added after each VRAM write
	logic [15:0] vramMod;
	logic wrMod;
	logic wrMode;

	// ============================================================
	// Write decode
	// ============================================================

	// Data port write, queues a VRAM write
	assign wrReq = cpu.wr && (cpu.addr == REG_VRAMRW);
	// Address load, queues a prefetch read
	assign rdReq = cpu.wr && (cpu.addr == REG_VRAMADDR);
	assign wrMod = cpu.wr && (cpu.addr == REG_VRAMMOD);
	assign wrMode = cpu.wr && (cpu.addr == REG_LSPCMODE);

	// ============================================================
	// Registers
	// ============================================================

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			vramAddr <= '0;
			vramWdata <= '0;
			vramMod <= '0;
			aaSpeed <= '0;
		end
		else
		begin
			// CPU load first, else step after a finished write
			// 16-bit wrap on the step
			if (rdReq)
				vramAddr <= cpu.wdata;
			else if (writeDone)
				vramAddr <= vramAddr + vramMod;

			// Held until the slot write goes out
			if (wrReq)
				vramWdata <= cpu.wdata;

			if (wrMod)
				vramMod <= cpu.wdata;

			// Only the speed field of LSPCMODE is kept
			if (wrMode)
				aaSpeed <= cpu.wdata[AA_SPEED_LSB +: 8];
		end
	end

	// ============================================================
	// Read-back
	// ============================================================

	// Zero unless the CPU is reading
	always_comb
	begin
		cpuRdata = '0;
		if (cpu.rd)
		begin
			case (cpu.addr)
				// Both offsets return the latched VRAM word
				REG_VRAMADDR, REG_VRAMRW:
					cpuRdata = rdata;
				REG_VRAMMOD:
					cpuRdata = vramMod;
				REG_LSPCMODE:
				begin
					// Speed up top, live tile counter at the bottom
					cpuRdata[AA_SPEED_LSB +: 8] = aaSpeed;
					cpuRdata[2:0] = aaCount;
				end
				default:
					cpuRdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/autoAnimCounter.sv */
// Auto-animation counter, steps the 3-bit tile number every speed+1 frames
`timescale 1ns/1ns
`default_nettype none

module autoAnimCounter
(
	input wire logic CLK_24M,
	input wire logic T73A_OUT,
	input wire logic frameStrobe,
	input wire logic [7:0] aaSpeed,
	output logic [2:0] aaCount
);

	// Frames seen since last tile step
	logic [7:0] frameDiv;

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			frameDiv <= '0;
			aaCount <= '0;
		end
		else if (frameStrobe)
		begin
			// >= so a lowered speed takes effect at once
			if (frameDiv >= aaSpeed)
			begin
				frameDiv <= '0;
				// Wraps at 8 tiles
				aaCount <= aaCount + 3'd1;
			end
			else
			begin
				frameDiv <= frameDiv + 8'd1;
			end
		end
	end

	// Tile number moves only right behind a frame pulse
	aStepOnFrame: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		$changed(aaCount) |-> $past(frameStrobe))
		else $error("aaCount changed without frameStrobe");

endmodule

`default_nettype wire

/* design/lspcVramCore.sv */
// LSPC VRAM core, ties sequencer, access FSM, registers and auto-animation
`timescale 1ns/1ns
`default_nettype none

module lspcVramCore
(
	input wire logic CLK_24M,
	input wire logic T73A_OUT,
	input wire lspcRegsPkg::cpuReq_t cpu,
	input wire logic frameStrobe,
	input wire logic [15:0] svramRdata,
	output vramBusPkg::vramReq_t svram,
	output logic [15:0] cpuRdata,
	output logic [2:0] aaCount
);

	// ============================================================
	// Internal wiring
	// ============================================================

	// CPU slot marker
	logic cpuSlot;
	// Register block to FSM
	logic wrReq;
	logic rdReq;
	logic [15:0] vramAddr;
	logic [15:0] vramWdata;
	// FSM back to register block
	logic writeDone;
	logic [15:0] rdata;
	// Mode field to animation counter
	logic [7:0] aaSpeed;

	slotSequencer uSeq
	(
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.cpuSlot(cpuSlot)
	);

	vramAccessFsm uFsm
	(
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.cpuSlot(cpuSlot),
		.wrReq(wrReq),
		.rdReq(rdReq),
		.vramAddr(vramAddr),
		.vramWdata(vramWdata),
		.svramRdata(svramRdata),
		.svram(svram),
		.writeDone(writeDone),
		.rdata(rdata)
	);

	cpuVramRegs uRegs
	(
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.cpu(cpu),
		.writeDone(writeDone),
		.rdata(rdata),
		.aaCount(aaCount),
		.wrReq(wrReq),
		.rdReq(rdReq),
		.vramAddr(vramAddr),
		.vramWdata(vramWdata),
		.aaSpeed(aaSpeed),
		.cpuRdata(cpuRdata)
	);

	autoAnimCounter uAnim
	(
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.frameStrobe(frameStrobe),
		.aaSpeed(aaSpeed),
		.aaCount(aaCount)
	);

endmodule

`default_nettype wire

/* tests/tbCpuTasks.svh */
// CPU bus tasks, LFSR source and expected-value models for the LSPC VRAM testbench
`ifndef TB_CPU_TASKS_SVH
`define TB_CPU_TASKS_SVH

// ============================================================
// Random source
// ============================================================

// Galois form, taps 32 31 29 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
	if (s[0])
		return (s >> 1) ^ 32'hD0000001;
	return s >> 1;
endfunction

// One LFSR step per bit taken, newest bit lands in bit 0
task automatic takeBits(input int n, output logic [31:0] v);
	v = '0;
	repeat (n)
	begin
		lfsr = lfsrNext(lfsr);
		v = {v[30:0], lfsr[0]};
	end
endtask

// ============================================================
// Expected-value models
// ============================================================

// Power-up VRAM contents, every address bit shows up in the word
function automatic logic [15:0] fillWord(input logic [14:0] a);
	return {a[6:0], a[14:7], ~a[0]} ^ 16'hC35A;
endfunction

// Read-back per offset
function automatic logic [15:0] readModel(input logic [2:0] addr, input logic [15:0] latched,
	input logic [15:0] modulo, input logic [7:0] speed, input logic [2:0] count);
	logic [15:0] r;
	r = '0;
	case (addr)
		REG_VRAMADDR, REG_VRAMRW:
			r = latched;
		REG_VRAMMOD:
			r = modulo;
		REG_LSPCMODE:
			r = {speed, 5'd0, count};
		default:
			r = '0;
	endcase
	return r;
endfunction

// ============================================================
// CPU bus tasks, all start 1 ns after a rising edge
// ============================================================

task automatic stepCycle;
	@(posedge CLK_24M);
	#1;
endtask

task automatic pause(input int n);
	repeat (n)
		stepCycle();
endtask

// rd held for one cycle, checked by the read-back assertion
task automatic cpuRead(input logic [2:0] addr);
	cpu.addr = addr;
	cpu.rd = 1'b1;
	stepCycle();
	cpu.rd = 1'b0;
endtask

// One-cycle write strobe plus the matching model update
task automatic cpuWrite(input logic [2:0] addr, input logic [15:0] data);
	cpu.addr = addr;
	cpu.wdata = data;
	cpu.wr = 1'b1;
	case (addr)
		REG_VRAMADDR:
		begin
			// Address load also fetches the word at the new address
			expAddr = data;
			readAddr = data;
			readCycle = cycleCnt;
			expLatched = refMem[data[14:0]];
			rdIssued++;
		end
		REG_VRAMRW:
		begin
			pendAddr = expAddr;
			pendData = data;
			strobeCycle = cycleCnt;
			refMem[expAddr[14:0]] = data;
			// Next write lands one modulo further on, 16-bit wrap
			expAddr = expAddr + expMod;
			wrIssued++;
		end
		REG_VRAMMOD:
			expMod = data;
		default:
			expSpeed = data[15:8];
	endcase
	stepCycle();
	cpu.wr = 1'b0;
endtask

`endif

/* tests/tbLspcVram.sv */
// LSPC VRAM core testbench, CPU stimulus with assertion checks against a VRAM model
`timescale 1ns/1ns
`default_nettype none

module tbLspcVram;
	import lspcRegsPkg::*;
	import vramBusPkg::*;

	localparam logic [31:0] SEED = 32'h98dbac18;
	localparam int NUM_WRITES = 8;
	localparam int NUM_READS = 4;
	localparam int NUM_FRAMES = 37;
	// Every sequence fits in 16 cycles
	localparam int SEQ_COUNT = 16 + NUM_WRITES + 3 * NUM_READS + NUM_FRAMES;
	localparam int TIMEOUT_NS = (SEQ_COUNT + 8) * 16 * 10;

	// DUT ports
	logic CLK_24M;
	logic T73A_OUT;
	cpuReq_t cpu;
	logic frameStrobe;
	logic [15:0] svramRdata;
	vramReq_t svram;
	logic [15:0] cpuRdata;
	logic [2:0] aaCount;

	// VRAM model and reference copy
	logic [15:0] vram [0:32767];
	logic [15:0] refMem [0:32767];

	// Model state, written by the CPU tasks
	logic [31:0] lfsr;
	logic [15:0] expAddr = '0;
	logic [15:0] expMod = '0;
	logic [7:0] expSpeed = '0;
	logic [15:0] expLatched = '0;
	logic [15:0] pendAddr = '0;
	logic [15:0] pendData = '0;
	logic [15:0] readAddr = '0;
	int strobeCycle = 0;
	int readCycle = 0;
	int wrIssued = 0;
	int rdIssued = 0;

	// Bus bookkeeping, clocked
	int cycleCnt = 0;
	int wrDone = 0;
	int rdDone = 0;
	int framesSeen = 0;
	int lastAccess = 0;
	bit accessSeen = 1'b0;

	logic [2:0] expCount;
	logic [15:0] expRead;

	`include "tbCpuTasks.svh"

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic reportMismatch(input string sig, input logic [31:0] expv,
		input logic [31:0] actv);
		abortRun($sformatf("MISMATCH at %0t: %s expected %h got %h", $time, sig, expv, actv));
	endtask

	lspcVramCore uut
	(
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT),
		.cpu(cpu),
		.frameStrobe(frameStrobe),
		.svramRdata(svramRdata),
		.svram(svram),
		.cpuRdata(cpuRdata),
		.aaCount(aaCount)
	);

	initial CLK_24M = 1'b0;
	always #5 CLK_24M = ~CLK_24M;

	// ============================================================
	// VRAM model and bookkeeping
	// ============================================================

	// Combinational read, write on we
	assign svramRdata = vram[svram.addr];
	always @(posedge CLK_24M)
		if (svram.we)
			vram[svram.addr] <= svram.wdata;

	always @(posedge CLK_24M)
	begin
		cycleCnt <= cycleCnt + 1;
		if (svram.we)
			wrDone <= wrDone + 1;
		if (svram.re)
			rdDone <= rdDone + 1;
		if (frameStrobe)
			framesSeen <= framesSeen + 1;
		if (svram.we || svram.re)
		begin
			lastAccess <= cycleCnt;
			accessSeen <= 1'b1;
		end
	end

	// Tile count after framesSeen strobes at speed expSpeed
	assign expCount = 3'((framesSeen / (int'(expSpeed) + 1)) % 8);
	assign expRead = readModel(cpu.addr, expLatched, expMod, expSpeed, expCount);

	// ============================================================
	// Checks
	// ============================================================

	aQuiet: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		(wrIssued + rdIssued == 0) |-> !(svram.we || svram.re))
		else abortRun("VRAM access seen before any CPU access");
	aWeRe: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		!(svram.we && svram.re))
		else abortRun("svram.we and svram.re high in the same cycle");
	aSpacing: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		(svram.we || svram.re) && accessSeen |-> (cycleCnt - lastAccess >= 8))
		else abortRun("two VRAM accesses less than 8 cycles apart");
	aWeWanted: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		svram.we |-> (wrIssued != wrDone))
		else abortRun("VRAM write pulse with no CPU write outstanding");
	aWeAddr: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		svram.we |-> (svram.addr == pendAddr[14:0]))
		else reportMismatch("svram.addr", $sampled(pendAddr[14:0]), $sampled(svram.addr));
	aWeData: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		svram.we |-> (svram.wdata == pendData))
		else reportMismatch("svram.wdata", $sampled(pendData), $sampled(svram.wdata));
	aWeDelay: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		svram.we |-> ((cycleCnt - strobeCycle) inside {[2:9]}))
		else abortRun("VRAM write not 2 to 9 cycles after its strobe");
	aWeLost: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		!((wrIssued != wrDone) && (cycleCnt - strobeCycle > 9)))
		else abortRun("CPU write never reached VRAM");
	aReWanted: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		svram.re |-> (rdIssued != rdDone))
		else abortRun("VRAM read pulse with no address load outstanding");
	aReAddr: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		svram.re |-> (svram.addr == readAddr[14:0]))
		else reportMismatch("svram.addr", $sampled(readAddr[14:0]), $sampled(svram.addr));
	aReLost: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		!((rdIssued != rdDone) && (cycleCnt - readCycle > 9)))
		else abortRun("address load never produced a VRAM read");
	aRead: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		cpu.rd |-> (cpuRdata == expRead))
		else reportMismatch("cpuRdata", $sampled(expRead), $sampled(cpuRdata));
	aCount: assert property (@(posedge CLK_24M) disable iff (!T73A_OUT)
		aaCount == expCount)
		else reportMismatch("aaCount", $sampled(expCount), $sampled(aaCount));

	// Hang guard
	initial
	begin
		#(TIMEOUT_NS);
		abortRun("watchdog expired, run did not finish in time");
	end

	// ============================================================
	// Stimulus
	// ============================================================

	initial
	begin
		logic [31:0] v;
		logic [15:0] word;
		logic [15:0] base;
		logic [15:0] modVal;
		lfsr = SEED;
		cpu = '0;
		frameStrobe = 1'b0;
		T73A_OUT = 1'b0;
		for (int i = 0; i < 32768; i++)
		begin
			vram[i] <= fillWord(15'(i));
			refMem[i] = fillWord(15'(i));
		end
		repeat (8) @(posedge CLK_24M);
		#1;
		T73A_OUT = 1'b1;

		// All offsets read zero, bus stays idle
		for (int i = 0; i < 4; i++)
			cpuRead(3'(i));
		pause(20);

		// Speed 0..3 so NUM_FRAMES wraps the tile counter
		takeBits(2, v);
		word = {6'd0, v[1:0], 8'd0};
		takeBits(8, v);
		word[7:0] = v[7:0];
		cpuWrite(REG_LSPCMODE, word);
		takeBits(16, v);
		modVal = v[15:0];
		cpuWrite(REG_VRAMMOD, modVal);
		cpuRead(REG_VRAMMOD);
		cpuRead(REG_LSPCMODE);

		// Write run from a random base
		takeBits(16, v);
		base = v[15:0];
		cpuWrite(REG_VRAMADDR, base);
		pause(12);
		for (int k = 0; k < NUM_WRITES; k++)
		begin
			takeBits(16, v);
			cpuWrite(REG_VRAMRW, v[15:0]);
			pause(12);
		end

		// Read back written words, last one from an untouched spot
		for (int k = 0; k < NUM_READS; k++)
		begin
			if (k == NUM_READS - 1)
			begin
				takeBits(16, v);
				word = v[15:0];
			end
			else
				word = 16'(base + 2 * k * modVal);
			cpuWrite(REG_VRAMADDR, word);
			pause(10);
			cpuRead(REG_VRAMADDR);
			cpuRead(REG_VRAMRW);
			pause(2);
		end

		// Frame pulses for the animation counter
		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			frameStrobe = 1'b1;
			stepCycle();
			frameStrobe = 1'b0;
			pause(2);
		end
		cpuRead(REG_LSPCMODE);
		pause(4);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tests
design/lspcRegsPkg.sv
design/vramBusPkg.sv
design/slotSequencer.sv
design/vramAccessFsm.sv
design/cpuVramRegs.sv
design/autoAnimCounter.sv
design/lspcVramCore.sv
tests/tbLspcVram.sv

/* Bender.yml */
package:
  name: lspc_vram_core

sources:
  - target: any(rtl, test)
    files:
      - design/lspcRegsPkg.sv
      - design/vramBusPkg.sv
      - design/slotSequencer.sv
      - design/vramAccessFsm.sv
      - design/cpuVramRegs.sv
      - design/autoAnimCounter.sv
      - design/lspcVramCore.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tbLspcVram.sv
